/* filelist.f */
+incdir+testbench
logic/link_pkg.sv
logic/axil_pkg.sv
logic/bit_sync.sv
logic/word_fifo.sv
logic/toggle_link_endpoint.sv
logic/mailbox_regs.sv
logic/mailbox_bridge_top.sv
testbench/tb_mailbox_bridge.sv

/* logic/axil_pkg.sv */
`default_nettype none

package axil_pkg;

	localparam int AXIL_ADDR_W = 4;
	localparam int AXIL_DATA_W = 32;
	localparam int AXIL_STRB_W = AXIL_DATA_W / 8;

	typedef enum logic [1:0] {
		OKAY   = 2'b00,
		SLVERR = 2'b10
	} axil_resp_e;

	// Register offsets of the mailbox
	typedef enum logic [AXIL_ADDR_W-1:0] {
		TX_DATA = 4'h0,
		RX_DATA = 4'h4,
		STATUS  = 4'h8
	} mbox_reg_e;

	// Channel bundles, ready travels back on its own wire
	typedef struct packed {
		logic                   valid;
		logic [AXIL_ADDR_W-1:0] addr;
	} axil_aw_t;

	typedef struct packed {
		logic                   valid;
		logic [AXIL_DATA_W-1:0] data;
		logic [AXIL_STRB_W-1:0] strb;
	} axil_w_t;

	typedef struct packed {
		logic       valid;
		axil_resp_e resp;
	} axil_b_t;

	typedef struct packed {
		logic                   valid;
		logic [AXIL_ADDR_W-1:0] addr;
	} axil_ar_t;

	typedef struct packed {
		logic                   valid;
		logic [AXIL_DATA_W-1:0] data;
		axil_resp_e             resp;
	} axil_r_t;

endpackage

`default_nettype wire

/* logic/bit_sync.sv */
`default_nettype none

module bit_sync #(
	parameter int WIDTH = 1
) (
	input  wire              rvx_port_00,
	input  wire              rvx_port_13,
	input  wire  [WIDTH-1:0] async_in,
	output logic [WIDTH-1:0] sync_out
);

	// First stage may go metastable
	logic [WIDTH-1:0] meta;

	always_ff @(posedge rvx_port_00 or negedge rvx_port_13)
	begin
		if (!rvx_port_13)
		begin
			meta     <= '0;
			sync_out <= '0;
		end
		else
		begin
			meta     <= async_in;
			sync_out <= meta;
		end
	end

endmodule

`default_nettype wire

/* logic/link_pkg.sv */
`default_nettype none

package link_pkg;

	// Width of one mailbox word on the link
	localparam int LINK_DATA_W = 32;

	// One direction of the two-phase link
	// A new word is announced by flipping toggle
	typedef struct packed {
		logic                   toggle;
		logic [LINK_DATA_W-1:0] data;
	} link_req_t;

	// Inbound engine, three stable samples before the push
	typedef enum logic [1:0] {
		rx_idle      = 2'd0,
		rx_seen_one  = 2'd1,
		rx_seen_two  = 2'd2,
		rx_push_wait = 2'd3
	} link_rx_state_e;

	// Outbound engine
	typedef enum logic {
		tx_idle      = 1'b0,
		tx_await_ack = 1'b1
	} link_tx_state_e;

endpackage

`default_nettype wire

/* logic/mailbox_bridge_top.sv */
`default_nettype none

module mailbox_bridge_top #(
	parameter int FIFO_DEPTH = 8
) (
	input  wire                  rvx_port_00,
	input  wire                  rvx_port_13,
	input  wire  axil_pkg::axil_aw_t aw,
	output logic                 awready,
	input  wire  axil_pkg::axil_w_t  w,
	output logic                 wready,
	output axil_pkg::axil_b_t    b,
	input  wire                  bready,
	input  wire  axil_pkg::axil_ar_t ar,
	output logic                 arready,
	output axil_pkg::axil_r_t    r,
	input  wire                  rready,
	input  wire  link_pkg::link_req_t in_req,
	output logic                 in_ack,
	output link_pkg::link_req_t  out_req,
	input  wire                  out_ack
);

	import link_pkg::*;

	localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

	// Register block to endpoint
	logic                   tx_push;
	logic [LINK_DATA_W-1:0] tx_word;
	logic                   tx_room;
	logic [CNT_W-1:0]       tx_count;
	logic                   rx_pop;
	logic [LINK_DATA_W-1:0] rx_word;
	logic                   rx_avail;
	logic [CNT_W-1:0]       rx_count;

	mailbox_regs #(.FIFO_DEPTH(FIFO_DEPTH)) u_regs (
		.rvx_port_00 (rvx_port_00),
		.rvx_port_13 (rvx_port_13),
		.aw          (aw),
		.awready     (awready),
		.w           (w),
		.wready      (wready),
		.b           (b),
		.bready      (bready),
		.ar          (ar),
		.arready     (arready),
		.r           (r),
		.rready      (rready),
		.tx_push     (tx_push),
		.tx_word     (tx_word),
		.tx_room     (tx_room),
		.tx_count    (tx_count),
		.rx_pop      (rx_pop),
		.rx_word     (rx_word),
		.rx_avail    (rx_avail),
		.rx_count    (rx_count)
	);

	toggle_link_endpoint #(.FIFO_DEPTH(FIFO_DEPTH)) u_endpoint (
		.rvx_port_00 (rvx_port_00),
		.rvx_port_13 (rvx_port_13),
		.in_req      (in_req),
		.in_ack      (in_ack),
		.out_req     (out_req),
		.out_ack     (out_ack),
		.tx_push     (tx_push),
		.tx_word     (tx_word),
		.tx_room     (tx_room),
		.tx_count    (tx_count),
		.rx_pop      (rx_pop),
		.rx_word     (rx_word),
		.rx_avail    (rx_avail),
		.rx_count    (rx_count)
	);

endmodule

`default_nettype wire

/* logic/mailbox_regs.sv */
`default_nettype none

module mailbox_regs #(
	parameter int FIFO_DEPTH = 8
) (
	input  wire                                  rvx_port_00,
	input  wire                                  rvx_port_13,
	input  wire  axil_pkg::axil_aw_t             aw,
	output logic                                 awready,
	input  wire  axil_pkg::axil_w_t              w,
	output logic                                 wready,
	output axil_pkg::axil_b_t                    b,
	input  wire                                  bready,
	input  wire  axil_pkg::axil_ar_t             ar,
	output logic                                 arready,
	output axil_pkg::axil_r_t                    r,
	input  wire                                  rready,
	output logic                                 tx_push,
	output logic [axil_pkg::AXIL_DATA_W-1:0]     tx_word,
	input  wire                                  tx_room,
	input  wire  [$clog2(FIFO_DEPTH+1)-1:0]      tx_count,
	output logic                                 rx_pop,
	input  wire  [axil_pkg::AXIL_DATA_W-1:0]     rx_word,
	input  wire                                  rx_avail,
	input  wire  [$clog2(FIFO_DEPTH+1)-1:0]      rx_count
);

	import axil_pkg::*;

	axil_b_t                b_q;
	axil_r_t                r_q;
	mbox_reg_e              wr_reg;
	mbox_reg_e              rd_reg;
	logic                   wr_fire;
	logic                   rd_fire;
	logic [AXIL_DATA_W-1:0] wr_mask;
	logic [AXIL_DATA_W-1:0] status_word;

	assign wr_reg = mbox_reg_e'(aw.addr);
	assign rd_reg = mbox_reg_e'(ar.addr);

	// Transmit count in the upper half, receive count in the lower
	assign status_word = {16'(tx_count), 16'(rx_count)};

	// **********************************************************************
	// Write channel
	// **********************************************************************

	// Byte lanes without strobe are sent as zero
	always_comb
	begin
		for (int i = 0; i < AXIL_STRB_W; i++)
			wr_mask[i*8 +: 8] = {8{w.strb[i]}};
	end

	// AW and W are taken together, one write in flight
	assign wr_fire = aw.valid && w.valid && !b_q.valid;
	assign awready = wr_fire;
	assign wready  = wr_fire;
	assign tx_push = wr_fire && (wr_reg == TX_DATA) && tx_room;
	assign tx_word = w.data & wr_mask;
	assign b       = b_q;

	always_ff @(posedge rvx_port_00 or negedge rvx_port_13)
	begin
		if (!rvx_port_13)
			b_q <= '0;
		else if (wr_fire)
		begin
			b_q.valid <= 1'b1;
			// Full FIFO or read-only target drops the word
			b_q.resp  <= tx_push ? OKAY : SLVERR;
		end
		else if (bready)
			b_q.valid <= 1'b0;
	end

	// **********************************************************************
	// Read channel
	// **********************************************************************

	assign rd_fire = ar.valid && !r_q.valid;
	assign arready = rd_fire;
	assign rx_pop  = rd_fire && (rd_reg == RX_DATA) && rx_avail;
	assign r       = r_q;

	always_ff @(posedge rvx_port_00 or negedge rvx_port_13)
	begin
		if (!rvx_port_13)
			r_q <= '0;
		else if (rd_fire)
		begin
			r_q.valid <= 1'b1;
			case (rd_reg)
				RX_DATA:
				begin
					// Head is latched in the same cycle it is popped
					r_q.data <= rx_avail ? rx_word : '0;
					r_q.resp <= rx_avail ? OKAY : SLVERR;
				end
				STATUS:
				begin
					r_q.data <= status_word;
					r_q.resp <= OKAY;
				end
				default:
				begin
					// TX_DATA is write only
					r_q.data <= '0;
					r_q.resp <= SLVERR;
				end
			endcase
		end
		else if (rready)
			r_q.valid <= 1'b0;
	end

endmodule

`default_nettype wire

/* logic/toggle_link_endpoint.sv */
`default_nettype none

module toggle_link_endpoint #(
	parameter int FIFO_DEPTH = 8
) (
	input  wire                                      rvx_port_00,
	input  wire                                      rvx_port_13,
	input  wire  link_pkg::link_req_t                in_req,
	output logic                                     in_ack,
	output link_pkg::link_req_t                      out_req,
	input  wire                                      out_ack,
	input  wire                                      tx_push,
	input  wire  [link_pkg::LINK_DATA_W-1:0]         tx_word,
	output logic                                     tx_room,
	output logic [$clog2(FIFO_DEPTH+1)-1:0]          tx_count,
	input  wire                                      rx_pop,
	output logic [link_pkg::LINK_DATA_W-1:0]         rx_word,
	output logic                                     rx_avail,
	output logic [$clog2(FIFO_DEPTH+1)-1:0]          rx_count
);

	import link_pkg::*;

	link_req_t              in_sync;
	logic                   out_ack_sync;
	link_rx_state_e         rx_state;
	link_tx_state_e         tx_state;
	logic                   rx_room;
	logic                   rx_push;
	logic                   toggle_diff;
	logic                   out_toggle;
	logic                   tx_avail;
	logic                   tx_pop;
	logic [LINK_DATA_W-1:0] tx_head;

	// **********************************************************************
	// Inbound path
	// **********************************************************************

	// Toggle and data cross together
	bit_sync #(.WIDTH($bits(link_req_t))) u_in_sync (
		.rvx_port_00 (rvx_port_00),
		.rvx_port_13 (rvx_port_13),
		.async_in    (in_req),
		.sync_out    (in_sync)
	);

	word_fifo #(.FIFO_DEPTH(FIFO_DEPTH), .WIDTH(LINK_DATA_W)) u_rx_fifo (
		.rvx_port_00 (rvx_port_00),
		.rvx_port_13 (rvx_port_13),
		.push        (rx_push),
		.wdata       (in_sync.data),
		.room        (rx_room),
		.pop         (rx_pop),
		.rdata       (rx_word),
		.avail       (rx_avail),
		.count       (rx_count)
	);

	assign toggle_diff = (in_sync.toggle != in_ack);
	assign rx_push     = (rx_state == rx_push_wait) && rx_room;

	// Three matching samples in a row filter a glitch on the toggle
	always_ff @(posedge rvx_port_00 or negedge rvx_port_13)
	begin
		if (!rvx_port_13)
		begin
			rx_state <= rx_idle;
			in_ack   <= 1'b0;
		end
		else
		begin
			case (rx_state)
				rx_idle:
					if (toggle_diff)
						rx_state <= rx_seen_one;
				rx_seen_one:
					rx_state <= toggle_diff ? rx_seen_two : rx_idle;
				rx_seen_two:
					rx_state <= toggle_diff ? rx_push_wait : rx_idle;
				rx_push_wait:
					// Full FIFO holds the ack back from the peer
					if (rx_room)
					begin
						rx_state <= rx_idle;
						in_ack   <= ~in_ack;
					end
			endcase
		end
	end

	// **********************************************************************
	// Outbound path
	// **********************************************************************

	bit_sync #(.WIDTH(1)) u_ack_sync (
		.rvx_port_00 (rvx_port_00),
		.rvx_port_13 (rvx_port_13),
		.async_in    (out_ack),
		.sync_out    (out_ack_sync)
	);

	word_fifo #(.FIFO_DEPTH(FIFO_DEPTH), .WIDTH(LINK_DATA_W)) u_tx_fifo (
		.rvx_port_00 (rvx_port_00),
		.rvx_port_13 (rvx_port_13),
		.push        (tx_push),
		.wdata       (tx_word),
		.room        (tx_room),
		.pop         (tx_pop),
		.rdata       (tx_head),
		.avail       (tx_avail),
		.count       (tx_count)
	);

	// Head stays put until the matching ack pops it
	assign out_req = '{toggle: out_toggle, data: tx_head};
	assign tx_pop  = (tx_state == tx_await_ack) && (out_toggle == out_ack_sync);

	always_ff @(posedge rvx_port_00 or negedge rvx_port_13)
	begin
		if (!rvx_port_13)
		begin
			tx_state   <= tx_idle;
			out_toggle <= 1'b0;
		end
		else
		begin
			case (tx_state)
				tx_idle:
					if (tx_avail)
					begin
						tx_state   <= tx_await_ack;
						out_toggle <= ~out_toggle;
					end
				tx_await_ack:
					if (tx_pop)
						tx_state <= tx_idle;
			endcase
		end
	end

endmodule

`default_nettype wire

/* logic/word_fifo.sv */
`default_nettype none

module word_fifo #(
	parameter int FIFO_DEPTH = 8,
	parameter int WIDTH      = 32
) (
	input  wire                                rvx_port_00,
	input  wire                                rvx_port_13,
	input  wire                                push,
	input  wire  [WIDTH-1:0]                   wdata,
	output logic                               room,
	input  wire                                pop,
	output logic [WIDTH-1:0]                   rdata,
	output logic                               avail,
	output logic [$clog2(FIFO_DEPTH+1)-1:0]    count
);

	localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
	localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

	logic [WIDTH-1:0] mem [FIFO_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] fill;
	logic             do_push;
	logic             do_pop;

	// Wrap at the last slot, depth need not be a power of two
	function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
		if (p == PTR_W'(FIFO_DEPTH - 1))
			return '0;
		return p + 1'b1;
	endfunction

	assign room    = (fill != CNT_W'(FIFO_DEPTH));
	assign avail   = (fill != '0);
	assign do_push = push && room;
	assign do_pop  = pop && avail;
	assign count   = fill;
	assign rdata   = avail ? mem[rd_ptr] : '0;

	always_ff @(posedge rvx_port_00)
	begin
		if (do_push)
			mem[wr_ptr] <= wdata;
	end

	always_ff @(posedge rvx_port_00 or negedge rvx_port_13)
	begin
		if (!rvx_port_13)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			fill   <= '0;
		end
		else
		begin
			if (do_push)
				wr_ptr <= next_ptr(wr_ptr);
			if (do_pop)
				rd_ptr <= next_ptr(rd_ptr);
			// Simultaneous push and pop leaves the fill unchanged
			if (do_push && !do_pop)
				fill <= fill + 1'b1;
			else if (do_pop && !do_push)
				fill <= fill - 1'b1;
		end
	end

endmodule

`default_nettype wire

/* run_sim.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	-f filelist.f --top-module tb_mailbox_bridge -o tb_mailbox_bridge

./obj_dir/tb_mailbox_bridge > sim.log 2>&1 || true
cat sim.log

if grep -q "Test failed" sim.log; then
	exit 1
fi
grep -q "Test completed successfully" sim.log

/* testbench/tb_link_peer.svh */
`ifndef TB_LINK_PEER_SVH
`define TB_LINK_PEER_SVH

// Peer side of the toggle link, run on the testbench clock
// Data only changes while the request toggle equals the acknowledge

// Present a new word, then announce it one cycle later
task automatic offer_word(input logic [31:0] data);
	@(negedge clk);
	in_req.data = data;
	@(negedge clk);
	in_req.toggle = ~in_req.toggle;
endtask

// The endpoint accepts by matching the request toggle
task automatic await_word_ack();
	while (in_ack !== in_req.toggle)
		@(negedge clk);
endtask

task automatic send_word(input logic [31:0] data);
	offer_word(data);
	await_word_ack();
endtask

// Take one outbound word and acknowledge it after a random pause
task automatic receive_word(output logic [31:0] data);
	int pause;
	while (out_req.toggle === out_ack)
		@(negedge clk);
	data  = out_req.data;
	pause = $unsigned($random(seed)) % 4;
	repeat (pause)
		@(negedge clk);
	out_ack = ~out_ack;
endtask

`endif

/* testbench/tb_mailbox_bridge.sv */
`default_nettype none

module tb_mailbox_bridge;

	import axil_pkg::*;
	import link_pkg::*;

	localparam int         FIFO_DEPTH  = 8;
	localparam int         OUT_WORDS   = 12;
	localparam int         IN_WORDS    = 6;
	localparam int         TOTAL_WORDS = OUT_WORDS + IN_WORDS + 2 * (FIFO_DEPTH + 1);
	localparam int         WATCHDOG    = TOTAL_WORDS * 200 + 2000;
	localparam logic [3:0] UNMAPPED    = 4'hC;

	logic        clk;
	logic        rst_n;
	axil_aw_t    aw;
	logic        awready;
	axil_w_t     w;
	logic        wready;
	axil_b_t     b;
	logic        bready;
	axil_ar_t    ar;
	logic        arready;
	axil_r_t     r;
	logic        rready;
	link_req_t   in_req;
	logic        in_ack;
	link_req_t   out_req;
	logic        out_ack;

	integer      seed;
	logic [31:0] word;
	logic [31:0] sent_q[$];
	logic [31:0] got_q[$];
	int          aw_hs_count;
	int          ar_hs_count;

	mailbox_bridge_top #(.FIFO_DEPTH(FIFO_DEPTH)) dut0 (
		.rvx_port_00 (clk),
		.rvx_port_13 (rst_n),
		.aw          (aw),
		.awready     (awready),
		.w           (w),
		.wready      (wready),
		.b           (b),
		.bready      (bready),
		.ar          (ar),
		.arready     (arready),
		.r           (r),
		.rready      (rready),
		.in_req      (in_req),
		.in_ack      (in_ack),
		.out_req     (out_req),
		.out_ack     (out_ack)
	);

	always #20 clk = ~clk;

	// Address handshakes seen on the host bus
	always @(posedge clk)
	begin
		if (awready && wready)
			aw_hs_count <= aw_hs_count + 1;
		if (arready)
			ar_hs_count <= ar_hs_count + 1;
	end

	`include "tb_link_peer.svh"

	// **********************************************************************
	// Checks and bus tasks
	// **********************************************************************

	task automatic expect_eq(input string test, input logic [31:0] exp, input logic [31:0] act);
		assert (act === exp)
		else
		begin
			$display("ERR %s expected 0x%08h actual 0x%08h", test, exp, act);
			$display("Test failed");
			$fatal(1);
		end
	endtask

	task automatic expect_true(input string what, input logic cond);
		assert (cond === 1'b1)
		else
		begin
			$display("Unexpected behavior: %s", what);
			$display("Test failed");
			$fatal(1);
		end
	endtask

	// Transmit count in the upper half and receive count in the lower
	function automatic logic [31:0] status_value(input int tx, input int rx);
		return (32'(tx) << 16) | 32'(rx);
	endfunction

	task automatic idle_cycles(input int n);
		repeat (n)
			@(negedge clk);
	endtask

	// AW and W go out together and B is taken as soon as it shows
	task automatic write_reg(input string test, input logic [3:0] addr,
			input logic [31:0] data, input axil_resp_e exp_resp);
		int hs_before;
		@(negedge clk);
		hs_before = aw_hs_count;
		aw = '{valid: 1'b1, addr: addr};
		w  = '{valid: 1'b1, data: data, strb: 4'hF};
		@(negedge clk);
		while (!b.valid)
			@(negedge clk);
		aw.valid = 1'b0;
		w.valid  = 1'b0;
		expect_eq({test, " awready"}, 32'(hs_before + 1), 32'(aw_hs_count));
		expect_eq({test, " bresp"}, 32'(exp_resp), 32'(b.resp));
		bready = 1'b1;
		@(negedge clk);
		bready = 1'b0;
	endtask

	task automatic read_reg(input logic [3:0] addr, output logic [31:0] data,
			output axil_resp_e resp);
		@(negedge clk);
		ar = '{valid: 1'b1, addr: addr};
		@(negedge clk);
		while (!r.valid)
			@(negedge clk);
		ar.valid = 1'b0;
		data     = r.data;
		resp     = r.resp;
		rready   = 1'b1;
		@(negedge clk);
		rready = 1'b0;
	endtask

	task automatic expect_read(input string test, input logic [3:0] addr,
			input logic [31:0] exp_data, input axil_resp_e exp_resp);
		logic [31:0] data;
		axil_resp_e  resp;
		int          hs_before;
		hs_before = ar_hs_count;
		read_reg(addr, data, resp);
		expect_eq({test, " arready"}, 32'(hs_before + 1), 32'(ar_hs_count));
		expect_eq({test, " rresp"}, 32'(exp_resp), 32'(resp));
		expect_eq({test, " rdata"}, exp_data, data);
	endtask

	// Ends a run that hangs on a handshake
	initial
	begin
		repeat (WATCHDOG)
			@(posedge clk);
		$display("Timeout: the run did not finish within %0d cycles", WATCHDOG);
		$display("Test failed");
		$fatal(1);
	end

	// **********************************************************************
	// Test sequence
	// **********************************************************************

	initial
	begin
		seed        = 32'heeab5ffd;
		aw_hs_count = 0;
		ar_hs_count = 0;
		clk         = 1'b0;
		rst_n       = 1'b0;
		aw          = '0;
		w           = '0;
		bready      = 1'b0;
		ar          = '0;
		rready      = 1'b0;
		in_req      = '0;
		out_ack     = 1'b0;
		repeat (2)
			@(negedge clk);
		rst_n = 1'b1;

		// Reset values
		expect_eq("reset awready", 32'h0, 32'(awready));
		expect_eq("reset wready", 32'h0, 32'(wready));
		expect_eq("reset arready", 32'h0, 32'(arready));
		expect_eq("reset bvalid", 32'h0, 32'(b.valid));
		expect_eq("reset rvalid", 32'h0, 32'(r.valid));
		expect_eq("reset in_ack", 32'h0, 32'(in_ack));
		expect_eq("reset out_req toggle", 32'h0, 32'(out_req.toggle));
		expect_read("reset status", STATUS, 32'h0, OKAY);

		// Outbound words with the peer acknowledging in parallel
		for (int i = 0; i < OUT_WORDS; i++)
		begin
			word = $random(seed);
			sent_q.push_back(word);
		end
		fork
			begin
				for (int i = 0; i < OUT_WORDS; i++)
				begin
					write_reg("outbound write", TX_DATA, sent_q[i], OKAY);
					idle_cycles(5);
				end
			end
			begin
				logic [31:0] rx_data;
				for (int i = 0; i < OUT_WORDS; i++)
				begin
					receive_word(rx_data);
					got_q.push_back(rx_data);
				end
			end
		join
		for (int i = 0; i < OUT_WORDS; i++)
			expect_eq("outbound order", sent_q[i], got_q[i]);

		// Single cycle glitch on the request toggle is filtered
		@(negedge clk);
		in_req.toggle = ~in_req.toggle;
		@(negedge clk);
		in_req.toggle = ~in_req.toggle;
		idle_cycles(10);
		expect_eq("glitch in_ack", 32'h0, 32'(in_ack));
		expect_read("glitch status", STATUS, status_value(0, 0), OKAY);

		// Inbound words read back in order
		sent_q.delete();
		for (int i = 0; i < IN_WORDS; i++)
		begin
			word = $random(seed);
			sent_q.push_back(word);
			send_word(word);
		end
		for (int i = 0; i < IN_WORDS; i++)
			expect_read("inbound read", RX_DATA, sent_q[i], OKAY);

		// Outbound back-pressure while the peer holds its acknowledge
		sent_q.delete();
		got_q.delete();
		for (int i = 0; i < FIFO_DEPTH; i++)
		begin
			word = $random(seed);
			sent_q.push_back(word);
			write_reg("tx fill", TX_DATA, word, OKAY);
		end
		word = $random(seed);
		write_reg("tx overflow", TX_DATA, word, SLVERR);
		expect_read("tx full status", STATUS, status_value(FIFO_DEPTH, 0), OKAY);
		for (int i = 0; i < FIFO_DEPTH; i++)
		begin
			receive_word(word);
			got_q.push_back(word);
		end
		for (int i = 0; i < FIFO_DEPTH; i++)
			expect_eq("tx drain order", sent_q[i], got_q[i]);
		idle_cycles(10);
		expect_true("no request after the accepted words", out_req.toggle === out_ack);
		expect_read("tx drained status", STATUS, status_value(0, 0), OKAY);

		// Inbound back-pressure where the extra word waits for a host read
		sent_q.delete();
		for (int i = 0; i <= FIFO_DEPTH; i++)
		begin
			word = $random(seed);
			sent_q.push_back(word);
		end
		for (int i = 0; i < FIFO_DEPTH; i++)
			send_word(sent_q[i]);
		offer_word(sent_q[FIFO_DEPTH]);
		idle_cycles(20);
		expect_true("extra word held without acknowledge", in_ack !== in_req.toggle);
		expect_read("rx full status", STATUS, status_value(0, FIFO_DEPTH), OKAY);
		expect_read("rx first read", RX_DATA, sent_q[0], OKAY);
		await_word_ack();
		for (int i = 1; i <= FIFO_DEPTH; i++)
			expect_read("rx drain read", RX_DATA, sent_q[i], OKAY);
		expect_read("rx empty read", RX_DATA, 32'h0, SLVERR);
		expect_read("unmapped read", UNMAPPED, 32'h0, SLVERR);

		idle_cycles(2);
		$display("Test completed successfully");
		$finish;
	end

endmodule

`default_nettype wire
